// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
TOP        = cacheL1Tb
FILELIST   = tb.f
BUILD_DIR  = obj_dir
PASS_MSG   = TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== cacheArray.sv ====
// flush and reset clear only the valid bits; stale tag and data stay until the next fill
`default_nettype none
`timescale 1ns/1ps

module cacheArray (
  input  logic                clk,
  input  logic                rstN,
  input  cachePkg::cacheIndex rdIndex,
  output cachePkg::cacheTag   rdTag,
  output logic                rdValid,
  output cachePkg::cacheWord  rdData,
  input  logic                fill,
  input  cachePkg::cacheIndex fillIndex,
  input  cachePkg::cacheTag   fillTag,
  input  cachePkg::cacheWord  fillData,
  input  logic                invalidate,
  input  cachePkg::cacheIndex invIndex,
  input  cachePkg::cacheCfg   cfg
);

  localparam int lineCount = 2 ** $bits(cachePkg::cacheIndex);

  logic [lineCount-1:0] validQ;
  cachePkg::cacheTag    tagMem [lineCount];
  cachePkg::cacheWord   dataMem [lineCount];

  // combinational lookup so a hit resolves in the request cycle
  assign rdValid = validQ[rdIndex];
  assign rdTag   = tagMem[rdIndex];
  assign rdData  = dataMem[rdIndex];

  always_ff @(posedge clk) begin
    if (!rstN || cfg.flush) begin
      validQ <= '0;   // all lines at once
    end else if (fill) begin
      validQ[fillIndex] <= 1'b1;
    end else if (invalidate) begin
      validQ[invIndex] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tagMem[fillIndex]  <= fillTag;
      dataMem[fillIndex] <= fillData;
    end
  end

  // fills come only from a read miss and invalidates only from a write
  assertFillInv: assert property (@(posedge clk) disable iff (!rstN)
    !(fill && invalidate));

endmodule

`default_nettype wire

// ==== cacheController.sv ====
// one access in flight; host holds a single enable until cacheReady, memory answers once per request
`default_nettype none
`timescale 1ns/1ps

module cacheController (
  input  logic                clk,
  input  logic                rstN,
  input  cachePkg::cacheAddr  address,
  input  logic                readEnable,
  input  logic                writeEnable,
  input  cachePkg::cacheWord  dataIn,
  output cachePkg::cacheWord  dataOut,
  output logic                cacheReady,
  input  cachePkg::cacheCfg   cfg,
  output cachePkg::cacheIndex rdIndex,
  input  cachePkg::cacheTag   rdTag,
  input  logic                rdValid,
  input  cachePkg::cacheWord  rdData,
  output logic                fill,
  output cachePkg::cacheTag   fillTag,
  output cachePkg::cacheWord  fillData,
  output logic                invalidate,
  output cachePkg::memReq     memOut,
  input  cachePkg::cacheWord  memRdata,
  input  logic                memReady,
  output logic                hitPulse,
  output logic                missPulse
);

  cachePkg::ctrlState state;
  cachePkg::ctrlState stateNext;
  cachePkg::cacheTag  addrTag;
  logic               invalidAddr;
  logic               uncached;
  logic               tagMatch;
  logic               hit;
  logic               idle;
  logic               readHit;
  logic               startRead;
  logic               startWrite;

  assign rdIndex     = address[6:2];
  assign addrTag     = address[10:7];
  assign invalidAddr = address[31];
  assign uncached    = address[1] | ~cfg.enable;   // disabled cache bypasses everything
  assign tagMatch    = (rdTag == addrTag);
  assign hit         = rdValid & tagMatch & ~uncached;
  assign idle        = (state == cachePkg::stIdle);
  assign readHit     = idle & readEnable & ~invalidAddr & hit;
  assign startRead   = idle & readEnable & ~invalidAddr & ~hit;   // miss or bypass
  assign startWrite  = idle & writeEnable & ~invalidAddr;

  always_comb begin
    stateNext = state;
    case (state)
      cachePkg::stIdle: begin
        if (startRead) begin
          stateNext = cachePkg::stRead;
        end else if (startWrite) begin
          stateNext = cachePkg::stWrite;
        end
      end
      cachePkg::stRead, cachePkg::stWrite: begin
        if (memReady) begin
          stateNext = cachePkg::stReady;
        end
      end
      default: begin
        stateNext = cachePkg::stIdle;   // stReady lasts one cycle
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= cachePkg::stIdle;
    end else begin
      state <= stateNext;
    end
  end

  // raised in the idle cycle of the access, held for the whole memory wait
  assign memOut = '{
    addr:  address,
    wdata: dataIn,
    read:  (state == cachePkg::stRead) | startRead,
    write: (state == cachePkg::stWrite) | startWrite
  };

  assign fill       = (state == cachePkg::stRead) & memReady & ~uncached;
  assign fillTag    = addrTag;
  assign fillData   = memRdata;
  assign invalidate = (state == cachePkg::stWrite) & memReady & rdValid & tagMatch;

  // after a cached miss the line is already filled in stReady
  assign dataOut    = uncached ? memRdata : rdData;
  assign cacheReady = ~(readEnable | writeEnable)
                    | (state == cachePkg::stReady)
                    | readHit
                    | (idle & invalidAddr);

  assign hitPulse  = readHit;
  assign missPulse = startRead & ~uncached;   // leaving stIdle

  assertOneEnable: assert property (@(posedge clk) disable iff (!rstN)
    !(readEnable && writeEnable));

  // memory only answers a request issued on the way out of stIdle
  assertNoIdleReady: assert property (@(posedge clk) disable iff (!rstN)
    memReady |-> !idle);

endmodule

`default_nettype wire

// ==== cacheCsr.sv ====
// regAddr 0 enable, 1 flush (write-only), 2 hits, 3 misses; counters saturate, reset clears them
`default_nettype none
`timescale 1ns/1ps

module cacheCsr (
  input  logic               clk,
  input  logic               rstN,
  input  logic               regWrite,
  input  logic [1:0]         regAddr,
  input  cachePkg::cacheWord regWdata,
  output cachePkg::cacheWord regRdata,
  output cachePkg::cacheCfg  cfg,
  input  logic               hitPulse,
  input  logic               missPulse
);

  logic                enableQ;
  logic                flushQ;
  cachePkg::cacheCount hitCount;
  cachePkg::cacheCount missCount;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      enableQ <= 1'b1;
      flushQ  <= 1'b0;
    end else begin
      flushQ <= regWrite && (regAddr == 2'd1) && regWdata[0];   // single-cycle pulse
      if (regWrite && (regAddr == 2'd0)) begin
        enableQ <= regWdata[0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      hitCount  <= '0;
      missCount <= '0;
    end else begin
      if (hitPulse && (hitCount != '1)) begin
        hitCount <= hitCount + 1'b1;
      end
      if (missPulse && (missCount != '1)) begin
        missCount <= missCount + 1'b1;
      end
    end
  end

  assign cfg = '{enable: enableQ, flush: flushQ};

  always_comb begin
    case (regAddr)
      2'd0:    regRdata = {31'd0, enableQ};
      2'd1:    regRdata = '0;   // flush reads as zero
      2'd2:    regRdata = {16'd0, hitCount};
      default: regRdata = {16'd0, missCount};
    endcase
  end

endmodule

`default_nettype wire

// ==== cacheInput.txt ====
# columns: kind addr data expected (hex); R data = cycles to cacheReady, expected = word read
# W expected = cycles to cacheReady; C addr = register, data = value; S expected = register value
R 00000010 5 00000013
R 00000010 1 00000013
R 00000014 5 00000016
R 00000014 1 00000016
W 00000010 deadbeef 5
R 00000010 5 deadbeef
R 00000010 1 deadbeef
R 00000090 5 00000073
R 00000010 5 deadbeef
R 00000012 5 deadbeef
R 00000012 5 deadbeef
S 2 0 3
S 3 0 5
R 80000010 1 0
W 80000014 0000abcd 1
S 2 0 3
S 3 0 5
C 0 0 0
S 0 0 0
R 00000014 5 00000016
R 00000014 5 00000016
S 2 0 3
S 3 0 5
C 0 1 0
R 00000014 1 00000016
C 1 1 0
R 00000014 5 00000016
R 00000014 1 00000016
S 2 0 5
S 3 0 6
W 00000094 12345678 5
R 00000014 1 00000016
R 00000094 5 12345678
S 2 0 6
S 3 0 7
S 0 0 1

// ==== cacheL1Tb.sv ====
// runs the default DUT (memLatency 3) from cacheInput.txt in the project root; stops at first error
`default_nettype none
`timescale 1ns/1ps

module cacheL1Tb;

  localparam int    memLatency   = 3;
  localparam int    slackPerLine = 6;   // drive cycle, ready cycle and up to 3 idle cycles
  localparam string inputPath    = "cacheInput.txt";

  logic                clk;
  logic                rstN;
  cachePkg::cacheAddr  address;
  logic                readEnable;
  logic                writeEnable;
  cachePkg::cacheWord  dataIn;
  cachePkg::cacheWord  dataOut;
  logic                cacheReady;
  logic                regWrite;
  logic [1:0]          regAddr;
  cachePkg::cacheWord  regWdata;
  cachePkg::cacheWord  regRdata;

  int cycleCount = 0;
  int cycleLimit = 0;   // set once the input file has been sized

  cacheL1Top dut0 (
    .clk(clk), .rstN(rstN),
    .address(address), .readEnable(readEnable), .writeEnable(writeEnable),
    .dataIn(dataIn), .dataOut(dataOut), .cacheReady(cacheReady),
    .regWrite(regWrite), .regAddr(regAddr), .regWdata(regWdata), .regRdata(regRdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if ((cycleLimit > 0) && (cycleCount >= cycleLimit)) begin
      $display("timeout: the run took more than %0d cycles, an access never completed",
               cycleLimit);
      $display("TESTS FAILED");
      $fatal(1, "watchdog expired");
    end
  end

  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkWord(input string name, input cachePkg::cacheWord expected,
                           input cachePkg::cacheWord actual);
    if (actual !== expected) begin
      stopWithFailure($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic checkCount(input string name, input cachePkg::cacheCount expected,
                            input cachePkg::cacheCount actual);
    if (actual !== expected) begin
      stopWithFailure($sformatf("FAILED %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic checkCycles(input string name, input int expected, input int actual);
    if (actual != expected) begin
      stopWithFailure($sformatf("FAILED %s expected %0d cycles actual %0d cycles",
                                name, expected, actual));
    end
  endtask

  task automatic idleGap();
    int gap;
    gap = $urandom_range(3, 1);
    repeat (gap) @(posedge clk);
  endtask

  // starts on a rising edge, holds the request until cacheReady is seen
  task automatic hostAccess(input logic isWrite, input cachePkg::cacheAddr addr,
                            input cachePkg::cacheWord wdata,
                            output cachePkg::cacheWord rdata, output int cycles);
    address     <= addr;
    dataIn      <= wdata;
    readEnable  <= ~isWrite;
    writeEnable <= isWrite;
    cycles = 0;
    do begin
      @(negedge clk);   // outputs settled mid-cycle
      cycles++;
    end while (!cacheReady);
    rdata = dataOut;
    @(posedge clk);
    readEnable  <= 1'b0;
    writeEnable <= 1'b0;
    idleGap();
  endtask

  task automatic regWriteOp(input logic [1:0] addr, input cachePkg::cacheWord value);
    regWrite <= 1'b1;
    regAddr  <= addr;
    regWdata <= value;
    @(posedge clk);
    regWrite <= 1'b0;
    idleGap();
  endtask

  task automatic regReadOp(input logic [1:0] addr, output cachePkg::cacheWord value);
    regAddr <= addr;
    @(negedge clk);
    value = regRdata;   // combinational readback
    @(posedge clk);
    idleGap();
  endtask

  initial begin
    int                 fd;
    int                 status;
    int                 lineCount;
    int                 lineNo;
    int                 cycles;
    logic [7:0]         kindChar;
    logic [8*128-1:0]   lineBuf;
    cachePkg::cacheAddr opAddr;
    cachePkg::cacheWord opData;
    cachePkg::cacheWord opExpect;
    cachePkg::cacheWord result;
    string              testName;

    void'($urandom(32'h321b));
    rstN        = 1'b0;
    address     = '0;
    readEnable  = 1'b0;
    writeEnable = 1'b0;
    dataIn      = '0;
    regWrite    = 1'b0;
    regAddr     = '0;
    regWdata    = '0;

    fd = $fopen(inputPath, "r");
    if (fd == 0) begin
      stopWithFailure("could not open cacheInput.txt for reading");
    end
    lineCount = 0;
    while (!$feof(fd)) begin
      status = $fgets(lineBuf, fd);
      if (status > 0) begin
        lineCount++;
      end
    end
    $fclose(fd);
    cycleLimit = lineCount * (memLatency + slackPerLine) + 50;

    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);

    fd = $fopen(inputPath, "r");
    lineNo = 0;
    while (!$feof(fd)) begin
      status = $fscanf(fd, "%s", kindChar);
      if (status == 1) begin
        lineNo++;
        if (kindChar == "#") begin
          status = $fgets(lineBuf, fd);   // rest of a comment line
        end else begin
          status = $fscanf(fd, "%h %h %h", opAddr, opData, opExpect);
          testName = $sformatf("line %0d %s %h", lineNo, kindChar, opAddr);
          if (status != 3) begin
            stopWithFailure($sformatf("%s does not have four columns", testName));
          end
          case (kindChar)
            "R": begin
              hostAccess(1'b0, opAddr, '0, result, cycles);
              checkCycles(testName, int'(opData), cycles);
              if (!opAddr[31]) begin   // invalid address returns no data
                checkWord(testName, opExpect, result);
              end
            end
            "W": begin
              hostAccess(1'b1, opAddr, opData, result, cycles);
              checkCycles(testName, int'(opExpect), cycles);
            end
            "C": begin
              regWriteOp(opAddr[1:0], opData);
            end
            "S": begin
              regReadOp(opAddr[1:0], result);
              if (opAddr[1]) begin   // hit and miss counters
                checkCount(testName, cachePkg::cacheCount'(opExpect),
                           cachePkg::cacheCount'(result));
              end else begin
                checkWord(testName, opExpect, result);
              end
            end
            default: begin
              stopWithFailure($sformatf("%s has an unknown operation kind", testName));
            end
          endcase
        end
      end
    end
    $fclose(fd);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== cacheL1Top.sv ====
// memLatency at least 2; one host access at a time, enables held until cacheReady
`default_nettype none
`timescale 1ns/1ps

module cacheL1Top #(
  parameter int memLatency = 3,
  parameter int memWords   = 512
) (
  input  logic               clk,
  input  logic               rstN,
  input  cachePkg::cacheAddr address,
  input  logic               readEnable,
  input  logic               writeEnable,
  input  cachePkg::cacheWord dataIn,
  output cachePkg::cacheWord dataOut,
  output logic               cacheReady,
  input  logic               regWrite,
  input  logic [1:0]         regAddr,
  input  cachePkg::cacheWord regWdata,
  output cachePkg::cacheWord regRdata
);

  cachePkg::cacheCfg   cfg;
  cachePkg::cacheIndex rdIndex;
  cachePkg::cacheTag   rdTag;
  logic                rdValid;
  cachePkg::cacheWord  rdData;
  logic                fill;
  cachePkg::cacheTag   fillTag;
  cachePkg::cacheWord  fillData;
  logic                invalidate;
  cachePkg::memReq     memOut;
  cachePkg::cacheWord  memRdata;
  logic                memReady;
  logic                hitPulse;
  logic                missPulse;

  cacheController ctrl0 (
    .clk(clk), .rstN(rstN),
    .address(address), .readEnable(readEnable), .writeEnable(writeEnable),
    .dataIn(dataIn), .dataOut(dataOut), .cacheReady(cacheReady),
    .cfg(cfg),
    .rdIndex(rdIndex), .rdTag(rdTag), .rdValid(rdValid), .rdData(rdData),
    .fill(fill), .fillTag(fillTag), .fillData(fillData), .invalidate(invalidate),
    .memOut(memOut), .memRdata(memRdata), .memReady(memReady),
    .hitPulse(hitPulse), .missPulse(missPulse)
  );

  // fill and invalidate always target the line of the held address
  cacheArray array0 (
    .clk(clk), .rstN(rstN),
    .rdIndex(rdIndex), .rdTag(rdTag), .rdValid(rdValid), .rdData(rdData),
    .fill(fill), .fillIndex(rdIndex), .fillTag(fillTag), .fillData(fillData),
    .invalidate(invalidate), .invIndex(rdIndex),
    .cfg(cfg)
  );

  cacheCsr csr0 (
    .clk(clk), .rstN(rstN),
    .regWrite(regWrite), .regAddr(regAddr), .regWdata(regWdata), .regRdata(regRdata),
    .cfg(cfg),
    .hitPulse(hitPulse), .missPulse(missPulse)
  );

  mainMemory #(
    .memLatency(memLatency),
    .memWords(memWords)
  ) mem0 (
    .clk(clk), .rstN(rstN),
    .req(memOut), .rdata(memRdata), .ready(memReady)
  );

endmodule

`default_nettype wire

// ==== cachePkg.sv ====
// fixed layout of 32 one-word lines: index from address bits 6..2, tag from bits 10..7
`default_nettype none

package cachePkg;

  typedef logic [31:0] cacheAddr;
  typedef logic [31:0] cacheWord;
  typedef logic [4:0]  cacheIndex;  // address bits 6..2
  typedef logic [3:0]  cacheTag;    // address bits 10..7
  typedef logic [15:0] cacheCount;

  typedef enum logic [1:0] {
    stIdle,
    stRead,
    stWrite,
    stReady
  } ctrlState;

  // request from the controller to main memory
  typedef struct packed {
    cacheAddr addr;
    cacheWord wdata;
    logic     read;
    logic     write;
  } memReq;

  typedef struct packed {
    logic enable;
    logic flush;   // one-cycle pulse
  } cacheCfg;

endpackage

`default_nettype wire

// ==== mainMemory.sv ====
// memLatency must be at least 2; address bits 1..0 ignored, contents reset to word*3+7
`default_nettype none
`timescale 1ns/1ps

module mainMemory #(
  parameter int memLatency = 3,
  parameter int memWords   = 512
) (
  input  logic               clk,
  input  logic               rstN,
  input  cachePkg::memReq    req,
  output cachePkg::cacheWord rdata,
  output logic               ready
);

  localparam int addrBits = $clog2(memWords);
  localparam int cntBits  = $clog2(memLatency + 1);

  cachePkg::cacheWord  mem [memWords];
  logic [addrBits-1:0] wordAddr;
  logic [cntBits-1:0]  count;
  logic                busy;
  logic                done;

  assign wordAddr = req.addr[addrBits+1:2];
  assign done     = busy && (count == '0);

  // request seen at the first edge, ready memLatency cycles after it appeared
  always_ff @(posedge clk) begin
    if (!rstN) begin
      busy  <= 1'b0;
      count <= '0;
      ready <= 1'b0;
    end else begin
      ready <= done;
      if (busy) begin
        if (done) begin
          busy <= 1'b0;
        end else begin
          count <= count - 1'b1;
        end
      end else if ((req.read || req.write) && !ready) begin   // skip the held request
        busy  <= 1'b1;
        count <= cntBits'(memLatency - 2);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < memWords; i++) begin
        mem[i] <= cachePkg::cacheWord'(i * 3 + 7);
      end
    end else if (done && req.write) begin
      mem[wordAddr] <= req.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (done && req.read) begin
      rdata <= mem[wordAddr];   // held until the next read
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
cachePkg.sv
cacheArray.sv
cacheController.sv
cacheCsr.sv
mainMemory.sv
cacheL1Top.sv
cacheL1Tb.sv
